/* Bender.yml */
package:
  name: vga_player

sources:
  - rtl/vga_player_pkg.sv
  - rtl/vga_timing.sv
  - rtl/frame_sequencer.sv
  - rtl/qspi_row_reader.sv
  - rtl/row_buffer.sv
  - rtl/pixel_color.sv
  - rtl/pwm_audio.sv
  - rtl/vga_player_top.sv
  - target: simulation
    files:
      - sim/qspi_flash_model.sv
      - sim/tb_vga_player.sv

/* rtl/frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer #(
    parameter int H_ACTIVE     = 640,
    parameter int H_FRONT      = 16,
    parameter int H_SYNC       = 96,
    parameter int H_BACK       = 80,
    parameter int V_ACTIVE     = 480,
    parameter int FRAME_REPEAT = 3,
    parameter int FRAME_COUNT  = 16
) (
    input  wire                                   px_clk,
    input  wire                                   rst,
    input  wire vga_player_pkg::raster_t          raster,
    output logic                                  fetch_start,
    output logic [vga_player_pkg::ADDR_BITS-1:0]  fetch_addr,
    output logic [1:0]                            repeat_idx
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int BANDS   = V_ACTIVE / vga_player_pkg::BLOCK_PX;

    logic [15:0] frame_idx;
    logic        band_start;
    logic        blank_start;
    logic        refresh_end;
    logic [6:0]  band_next;

    // first line of bands 0..58 prefetches the following band
    assign band_start = raster.hcount == 0
        && raster.vcount % vga_player_pkg::BLOCK_PX == 0
        && raster.vcount < V_ACTIVE - vga_player_pkg::BLOCK_PX;
    // first blanking line prefetches band 0 of the next refresh
    assign blank_start = raster.hcount == 0 && raster.vcount == V_ACTIVE;
    assign refresh_end = raster.hcount == H_TOTAL - 1 && raster.vcount == V_ACTIVE - 1;

    assign fetch_start = band_start || blank_start;
    assign band_next   = blank_start ? 7'd0 : 7'(raster.vcount / vga_player_pkg::BLOCK_PX + 1);

    // row number times the row size gives the byte address
    assign fetch_addr = vga_player_pkg::ADDR_BITS'(
        (frame_idx * BANDS + band_next) * vga_player_pkg::ROW_BYTES);

    // counters step after the last active line, so the blanking fetch and
    // the band 0 swap already see the new refresh
    always_ff @(posedge px_clk) begin
        if (rst) begin
            repeat_idx <= '0;
            frame_idx  <= '0;
        end else if (refresh_end) begin
            if (repeat_idx == FRAME_REPEAT - 1) begin
                repeat_idx <= '0;
                // frame index wraps instead of running off the flash
                if (frame_idx == FRAME_COUNT - 1) begin
                    frame_idx <= '0;
                end else begin
                    frame_idx <= frame_idx + 1'b1;
                end
            end else begin
                repeat_idx <= repeat_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pixel_color.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_color (
    input  wire                            px_clk,
    input  wire                            rst,
    input  wire vga_player_pkg::raster_t   raster,
    input  wire vga_player_pkg::row_t      display_row,
    input  wire vga_player_pkg::color_t    color_on,
    input  wire vga_player_pkg::color_t    color_off,
    output vga_player_pkg::rgb_t           rgb,
    output logic                           hsync,
    output logic                           vsync
);

    logic [6:0] block;
    logic       pix_on;

    // each user bit drives both bits of its channel
    function automatic vga_player_pkg::rgb_t widen(input vga_player_pkg::color_t c);
        vga_player_pkg::rgb_t w;
        w.r = {2{c.r}};
        w.g = {2{c.g}};
        w.b = {2{c.b}};
        return w;
    endfunction

    assign block = 7'(raster.hcount / vga_player_pkg::BLOCK_PX);

    // leftmost block is row bit 79; blanking never indexes the row
    assign pix_on = raster.active
        ? display_row[vga_player_pkg::BLOCKS_X - 1 - block]
        : 1'b0;

    // colour and syncs leave together, one cycle behind the raster
    always_ff @(posedge px_clk) begin
        if (rst) begin
            rgb   <= widen(color_off);
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= widen(pix_on ? color_on : color_off);
            hsync <= raster.hsync;
            vsync <= raster.vsync;
        end
    end

endmodule

`default_nettype wire

/* rtl/pwm_audio.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_audio (
    input  wire                               px_clk,
    input  wire                               rst,
    input  wire vga_player_pkg::raster_t      raster,
    input  wire vga_player_pkg::sound_word_t  sound_word,
    input  wire                               sound_load,
    output logic                              sound_p,
    output logic                              sound_n
);

    logic [7:0] counter;
    logic [7:0] threshold;
    logic       half_band;

    // second sample of the pair takes over half way through the band
    assign half_band = raster.hcount == 0
        && raster.vcount % vga_player_pkg::BLOCK_PX == vga_player_pkg::BLOCK_PX / 2;

    always_ff @(posedge px_clk) begin
        if (rst) begin
            counter   <= '0;
            threshold <= '0;
            sound_p   <= 1'b0;
            sound_n   <= 1'b1;
        end else begin
            // 256 clock period, free running
            counter <= counter + 1'b1;
            if (sound_load) begin
                threshold <= sound_word[vga_player_pkg::SOUND_WORD_BITS-1 -: 8];
            end else if (half_band) begin
                threshold <= sound_word[7:0];
            end
            // differential pair, always complementary
            sound_p <= counter < threshold;
            sound_n <= !(counter < threshold);
        end
    end

endmodule

`default_nettype wire

/* rtl/qspi_row_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module qspi_row_reader (
    input  wire                                  px_clk,
    input  wire                                  rst,
    input  wire                                  fetch_start,
    input  wire [vga_player_pkg::ADDR_BITS-1:0]  fetch_addr,
    input  wire [3:0]                            io_in,
    output vga_player_pkg::qspi_out_t            qspi,
    output vga_player_pkg::row_t                 fetched_row,
    output logic                                 row_done
);

    localparam int CMD_CYCLES  = $bits(vga_player_pkg::READ_CMD);
    localparam int OUT_BITS    = CMD_CYCLES + vga_player_pkg::ADDR_BITS;
    // one extra cycle because the nibbles arrive a cycle late
    localparam int READ_CYCLES = vga_player_pkg::ROW_BITS / 4 + 1;

    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        COMMAND,
        ADDRESS,
        DUMMY,
        READ
    } phase_t;

    phase_t                 phase;
    phase_t                 phase_next;
    logic [5:0]             bit_cnt;
    logic [5:0]             phase_len;
    logic                   phase_end;
    logic [OUT_BITS-1:0]    out_sr;
    vga_player_pkg::row_t   row_sr;

    // length and successor of each clocked phase
    always_comb begin
        phase_len  = 6'd1;
        phase_next = IDLE;
        case (phase)
            SELECT: begin
                phase_next = COMMAND;
            end
            COMMAND: begin
                phase_len  = 6'(CMD_CYCLES);
                phase_next = ADDRESS;
            end
            ADDRESS: begin
                phase_len  = 6'(vga_player_pkg::ADDR_BITS);
                phase_next = DUMMY;
            end
            DUMMY: begin
                phase_len  = 6'(vga_player_pkg::DUMMY_CYCLES);
                phase_next = READ;
            end
            READ: begin
                phase_len  = 6'(READ_CYCLES);
                phase_next = IDLE;
            end
            default: begin
                phase_next = IDLE;
            end
        endcase
    end

    assign phase_end = bit_cnt == phase_len - 1'b1;

    always_ff @(posedge px_clk) begin
        if (rst) begin
            phase   <= IDLE;
            bit_cnt <= '0;
        end else if (phase == IDLE) begin
            bit_cnt <= '0;
            if (fetch_start) begin
                phase <= SELECT;
            end
        end else if (phase_end) begin
            bit_cnt <= '0;
            phase   <= phase_next;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // command and address go out msb first on io0
    always_ff @(posedge px_clk) begin
        if (phase == IDLE && fetch_start) begin
            out_sr <= {vga_player_pkg::READ_CMD, fetch_addr};
        end else if (phase == COMMAND || phase == ADDRESS) begin
            out_sr <= out_sr << 1;
        end
        // first read cycle shifts in a stale nibble that falls off the top
        if (phase == READ) begin
            row_sr <= {row_sr[vga_player_pkg::ROW_BITS-5:0], io_in};
        end
    end

    always_comb begin
        qspi.sel_n = phase == IDLE;
        // flash samples on the falling px_clk edge
        qspi.sclk  = ~px_clk && phase != IDLE && phase != SELECT;
        qspi.io_oe = phase == COMMAND || phase == ADDRESS;
        qspi.io0   = qspi.io_oe && out_sr[OUT_BITS-1];
    end

    // last nibble is taken straight from the pins in the final read cycle
    assign fetched_row = {row_sr[vga_player_pkg::ROW_BITS-5:0], io_in};
    assign row_done    = phase == READ && phase_end;

    // the sequencer spaces fetches far enough apart for a full read
    assert property (@(posedge px_clk) disable iff (rst)
        fetch_start |-> phase == IDLE)
        else $error("fetch_start while a row read is in progress");

endmodule

`default_nettype wire

/* rtl/row_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module row_buffer #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 80,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 36
) (
    input  wire                              px_clk,
    input  wire                              rst,
    input  wire vga_player_pkg::raster_t     raster,
    input  wire                              row_done,
    input  wire vga_player_pkg::row_t        fetched_row,
    input  wire [1:0]                        repeat_idx,
    output vga_player_pkg::row_t             display_row,
    output vga_player_pkg::sound_word_t      sound_word,
    output logic                             sound_load
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    vga_player_pkg::row_t cache_row;
    logic                 pending;
    logic                 band_end;
    logic                 swap;

    // last pixel of an active band, or of the frame for band 0
    assign band_end = raster.hcount == H_TOTAL - 1
        && ((raster.vcount % vga_player_pkg::BLOCK_PX == vga_player_pkg::BLOCK_PX - 1
             && raster.vcount < V_ACTIVE)
            || raster.vcount == V_TOTAL - 1);
    // without a fresh row the old one stays on screen
    assign swap = band_end && pending;

    always_ff @(posedge px_clk) begin
        if (row_done) begin
            cache_row <= fetched_row;
        end
    end

    always_ff @(posedge px_clk) begin
        if (rst) begin
            pending     <= 1'b0;
            display_row <= '0;
            sound_word  <= '0;
            sound_load  <= 1'b0;
        end else begin
            sound_load <= swap;
            if (row_done) begin
                pending <= 1'b1;
            end else if (swap) begin
                pending <= 1'b0;
            end
            if (swap) begin
                display_row <= cache_row;
                // word r sits 16r bits below the top of the row
                sound_word  <= cache_row[vga_player_pkg::ROW_BITS - 1
                    - vga_player_pkg::SOUND_WORD_BITS * repeat_idx
                    -: vga_player_pkg::SOUND_WORD_BITS];
            end
        end
    end

    // one row per band, so a second arrival would drop an unshown row
    assert property (@(posedge px_clk) disable iff (rst)
        row_done |-> !pending)
        else $error("row arrived before the previous one was swapped in");

endmodule

`default_nettype wire

/* rtl/vga_player_pkg.sv */
`default_nettype none

package vga_player_pkg;

    // flash row layout, one row per 8-line band
    localparam int ROW_BITS = 128;
    // byte step between consecutive rows in flash
    localparam int ROW_BYTES = 16;
    // block edge in pixels
    localparam int BLOCK_PX = 8;
    // pixel bits at the low end of each row
    localparam int BLOCKS_X = 80;
    // one sound word per refresh, packed above the pixel bits
    localparam int SOUND_WORD_BITS = 16;

    // fast read quad output
    localparam logic [7:0] READ_CMD = 8'h6B;
    localparam int ADDR_BITS = 24;
    localparam int DUMMY_CYCLES = 8;

    typedef logic [9:0] count_t;
    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic [SOUND_WORD_BITS-1:0] sound_word_t;

    // user colour, one bit per channel
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } color_t;

    // video output, two bits per channel
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    typedef struct packed {
        count_t hcount;
        count_t vcount;
        logic   hsync;
        logic   vsync;
        logic   active;
    } raster_t;

    // pins driven towards the flash
    typedef struct packed {
        logic sel_n;
        logic sclk;
        logic io0;
        logic io_oe;
    } qspi_out_t;

endpackage

`default_nettype wire

/* rtl/vga_player_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_player_top #(
    parameter int H_ACTIVE     = 640,
    parameter int H_FRONT      = 16,
    parameter int H_SYNC       = 96,
    parameter int H_BACK       = 80,
    parameter int V_ACTIVE     = 480,
    parameter int V_FRONT      = 1,
    parameter int V_SYNC       = 3,
    parameter int V_BACK       = 36,
    // refreshes per video frame
    parameter int FRAME_REPEAT = 3,
    // frames stored in flash
    parameter int FRAME_COUNT  = 16
) (
    input  wire                             px_clk,
    input  wire                             rst,
    input  wire vga_player_pkg::color_t     color_on,
    input  wire vga_player_pkg::color_t     color_off,
    input  wire [3:0]                       io_in,
    output vga_player_pkg::qspi_out_t       qspi,
    output vga_player_pkg::rgb_t            rgb,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            sound_p,
    output logic                            sound_n
);

    vga_player_pkg::raster_t               raster;
    logic                                  fetch_start;
    logic [vga_player_pkg::ADDR_BITS-1:0]  fetch_addr;
    logic [1:0]                            repeat_idx;
    logic                                  row_done;
    vga_player_pkg::row_t                  fetched_row;
    vga_player_pkg::row_t                  display_row;
    vga_player_pkg::sound_word_t           sound_word;
    logic                                  sound_load;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .px_clk (px_clk),
        .rst    (rst),
        .raster (raster)
    );

    frame_sequencer #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .FRAME_REPEAT(FRAME_REPEAT), .FRAME_COUNT(FRAME_COUNT)
    ) u_sequencer (
        .px_clk      (px_clk),
        .rst         (rst),
        .raster      (raster),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .repeat_idx  (repeat_idx)
    );

    qspi_row_reader u_reader (
        .px_clk      (px_clk),
        .rst         (rst),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .io_in       (io_in),
        .qspi        (qspi),
        .fetched_row (fetched_row),
        .row_done    (row_done)
    );

    row_buffer #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_row_buffer (
        .px_clk      (px_clk),
        .rst         (rst),
        .raster      (raster),
        .row_done    (row_done),
        .fetched_row (fetched_row),
        .repeat_idx  (repeat_idx),
        .display_row (display_row),
        .sound_word  (sound_word),
        .sound_load  (sound_load)
    );

    pixel_color u_pixel (
        .px_clk      (px_clk),
        .rst         (rst),
        .raster      (raster),
        .display_row (display_row),
        .color_on    (color_on),
        .color_off   (color_off),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    pwm_audio u_audio (
        .px_clk     (px_clk),
        .rst        (rst),
        .raster     (raster),
        .sound_word (sound_word),
        .sound_load (sound_load),
        .sound_p    (sound_p),
        .sound_n    (sound_n)
    );

endmodule

`default_nettype wire

/* rtl/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 80,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 3,
    parameter int V_BACK   = 36
) (
    input  wire                       px_clk,
    input  wire                       rst,
    output vga_player_pkg::raster_t   raster
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    // sync windows start right after the front porch
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    vga_player_pkg::count_t hcount;
    vga_player_pkg::count_t vcount;

    // pixel counter wraps at the line total, line counter at the frame total
    always_ff @(posedge px_clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == H_TOTAL - 1) begin
            hcount <= '0;
            if (vcount == V_TOTAL - 1) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    always_comb begin
        raster.hcount = hcount;
        raster.vcount = vcount;
        // both syncs are active low
        raster.hsync  = !(hcount >= H_SYNC_START && hcount < H_SYNC_START + H_SYNC);
        raster.vsync  = !(vcount >= V_SYNC_START && vcount < V_SYNC_START + V_SYNC);
        raster.active = hcount < H_ACTIVE && vcount < V_ACTIVE;
    end

    // downstream band and swap decodes rely on both counters staying in range
    assert property (@(posedge px_clk) disable iff (rst)
        hcount < H_TOTAL && vcount < V_TOTAL)
        else $error("raster counter out of range");

endmodule

`default_nettype wire

/* sim/qspi_flash_model.sv */
`timescale 1ns/1ps
`default_nettype none

module qspi_flash_model #(
    parameter string CASES_FILE = "sim/vga_player_cases.txt",
    parameter int    ROWS       = 128
) (
    input  wire       sel_n,
    input  wire       sclk,
    input  wire       io0,
    output logic [3:0] io
);

    logic [143:0]                          entries [0:63];
    vga_player_pkg::row_t                  rows [0:ROWS-1];
    logic [vga_player_pkg::ADDR_BITS-1:0]  addr;
    vga_player_pkg::row_t                  data;
    int                                    edge_cnt;

    initial begin
        io = '0;
        edge_cnt = 0;
        // unlisted rows repeat their own byte address
        for (int i = 0; i < ROWS; i++) begin
            rows[i] = vga_player_pkg::row_t'({6{24'(i * vga_player_pkg::ROW_BYTES)}});
        end
        for (int i = 0; i < 64; i++) begin
            entries[i] = '0;
        end
        $readmemh(CASES_FILE, entries);
        // tag 01 is a row entry, index in bits 135:128
        for (int i = 0; i < 64; i++) begin
            if (entries[i][143:136] == 8'h01) begin
                rows[entries[i][135:128]] = entries[i][127:0];
            end
        end
    end

    always @(posedge sel_n) begin
        edge_cnt = 0;
    end

    // command on edges 0..7, address on 8..31, dummy on 32..39
    always @(posedge sclk) begin
        if (!sel_n) begin
            if (edge_cnt >= 8 && edge_cnt < 32) begin
                addr = {addr[22:0], io0};
            end
            if (edge_cnt == 32) begin
                data = rows[(addr / vga_player_pkg::ROW_BYTES) % ROWS];
            end
            edge_cnt = edge_cnt + 1;
        end
    end

    // nibbles change on the falling edge, high nibble first
    always @(negedge sclk) begin
        if (!sel_n && edge_cnt >= 41 && edge_cnt <= 72) begin
            io <= data[127 - 4 * (edge_cnt - 41) -: 4];
        end
    end

endmodule

`default_nettype wire

/* sim/tb_vga_player.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vga_player;

    localparam int H_TOTAL        = 832;
    localparam int V_TOTAL        = 520;
    localparam int FRAME_REPEAT   = 3;
    localparam int FRAME_COUNT    = 2;
    localparam int BANDS          = 60;
    localparam int REFRESH_CYCLES = H_TOTAL * V_TOTAL;
    // enough refreshes to see the frame index wrap once
    localparam int N_READS        = (FRAME_REPEAT * FRAME_COUNT + 1) * BANDS;
    localparam int LIMIT          = (FRAME_REPEAT * FRAME_COUNT + 2) * REFRESH_CYCLES;

    logic                          px_clk;
    logic                          rst;
    vga_player_pkg::color_t        color_on;
    vga_player_pkg::color_t        color_off;
    logic [3:0]                    io_in;
    vga_player_pkg::qspi_out_t     qspi_pins;
    vga_player_pkg::rgb_t          rgb;
    logic                          hsync;
    logic                          vsync;
    logic                          sound_p;
    logic                          sound_n;
    wire                           sel_n = qspi_pins.sel_n;
    wire                           sclk = qspi_pins.sclk;

    logic [143:0] cases [0:63];
    int   probes[$];
    int   probe_ptr = 0;
    int   cyc = 0;
    int   timer = 0;
    int   addr_errs = 0;
    int   rgb_errs = 0;
    int   sync_errs = 0;
    int   pwm_errs = 0;
    int   other_errs = 0;
    int   reads_done = 0;
    int   addr_cnt = 0;
    int   sclk_bits = 0;
    int   sel_low = 0;
    int   pwm_high = 0;
    int   hs_low = 0;
    int   vs_low = 0;
    int   hs_fall = -1;
    int   vs_fall = -1;
    logic [31:0] shifted;
    int   seed;

    vga_player_top #(.FRAME_REPEAT(FRAME_REPEAT), .FRAME_COUNT(FRAME_COUNT)) UUT (
        .px_clk(px_clk), .rst(rst), .color_on(color_on), .color_off(color_off),
        .io_in(io_in), .qspi(qspi_pins), .rgb(rgb), .hsync(hsync), .vsync(vsync),
        .sound_p(sound_p), .sound_n(sound_n)
    );

    qspi_flash_model u_flash (.sel_n(sel_n), .sclk(sclk), .io0(qspi_pins.io0), .io(io_in));

    task automatic check_addr(input string what, input logic [23:0] got, input logic [23:0] exp);
        if (got !== exp) begin
            addr_errs++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rgb(input string what, input vga_player_pkg::rgb_t got,
                             input vga_player_pkg::rgb_t exp);
        if (got !== exp) begin
            rgb_errs++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_sync(input string what, input int got, input int exp);
        if (got !== exp) begin
            sync_errs++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_pwm(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            pwm_errs++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic print_error_counts();
        $display("errors: addr %0d rgb %0d sync %0d pwm %0d other %0d",
                 addr_errs, rgb_errs, sync_errs, pwm_errs, other_errs);
    endtask

    function automatic vga_player_pkg::rgb_t expand_color(input vga_player_pkg::color_t c);
        return {{2{c.r}}, {2{c.g}}, {2{c.b}}};
    endfunction

    // band 0 of the first refresh is never fetched and shows an all-zero row
    function automatic vga_player_pkg::row_t shown_row(input int refresh, input int band);
        if (refresh == 0 && band == 0) begin
            return '0;
        end
        return u_flash.rows[((refresh / FRAME_REPEAT) % FRAME_COUNT) * BANDS + band];
    endfunction

    initial begin
        px_clk = 1'b0;
        forever #20 px_clk = ~px_clk;
    end

    always @(posedge px_clk) begin
        timer <= timer + 1;
        if (!rst) begin
            cyc <= cyc + 1;
        end
        if (timer >= LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d row reads", timer, reads_done,
                     N_READS);
            print_error_counts();
            $display("Regression failed");
            $finish;
        end
    end

    // command and address bits as the flash sees them
    always @(posedge sclk) begin
        int u;
        if (!sel_n && sclk_bits < 32) begin
            shifted = {shifted[30:0], qspi_pins.io0};
            sclk_bits++;
            if (sclk_bits == 32) begin
                u = addr_cnt + 1;
                check_addr("read command", 24'(shifted[31:24]), 24'h6B);
                check_addr("row address", shifted[23:0],
                    24'((((u / BANDS) / FRAME_REPEAT) % FRAME_COUNT * BANDS + u % BANDS) * 16));
                addr_cnt++;
            end
        end
    end

    always @(negedge px_clk) begin
        int p;
        int h;
        int v;
        int refresh;
        int band;
        logic pix;
        vga_player_pkg::row_t row;
        if (!rst && cyc > 0) begin
            // rgb now reflects the raster position of the previous cycle
            p = cyc - 1;
            h = p % H_TOTAL;
            v = (p / H_TOTAL) % V_TOTAL;
            refresh = p / REFRESH_CYCLES;
            band = v / 8;
            row = shown_row(refresh, band);
            if (probe_ptr < probes.size() && p == probes[probe_ptr]) begin
                pix = (h < 640 && v < 480) ? row[79 - h / 8] : 1'b0;
                check_rgb("probe colour", rgb, expand_color(pix ? color_on : color_off));
                probe_ptr++;
            end
            // duty over one counter period on line 1 of each band
            if (v < 480 && v % 8 == 1 && h < 256) begin
                pwm_high += sound_p;
                if (h == 255) begin
                    check_pwm("sound duty", 8'(pwm_high),
                              row[127 - 16 * (refresh % FRAME_REPEAT) -: 8]);
                    pwm_high = 0;
                end
            end
            if (!hsync) begin
                if (hs_low == 0 && hs_fall >= 0) begin
                    check_sync("hsync period", p - hs_fall, H_TOTAL);
                end
                if (hs_low == 0) begin
                    hs_fall = p;
                end
                hs_low++;
            end else if (hs_low > 0) begin
                check_sync("hsync width", hs_low, 96);
                hs_low = 0;
            end
            if (!vsync) begin
                if (vs_low == 0 && vs_fall >= 0) begin
                    check_sync("vsync period", p - vs_fall, REFRESH_CYCLES);
                end
                if (vs_low == 0) begin
                    vs_fall = p;
                end
                vs_low++;
            end else if (vs_low > 0) begin
                check_sync("vsync width", vs_low, 3 * H_TOTAL);
                vs_low = 0;
            end
        end
        if (!sel_n) begin
            sel_low++;
        end else if (sel_low > 0) begin
            check_sync("select low time", sel_low, 74);
            sel_low = 0;
            sclk_bits = 0;
            reads_done++;
        end
    end

    initial begin
        rst = 1'b1;
        color_on = '0;
        color_off = '0;
        seed = $urandom(30);
        for (int i = 0; i < 64; i++) begin
            cases[i] = '0;
        end
        $readmemh("sim/vga_player_cases.txt", cases);
        // tag 02 is a probe: refresh, vcount, hcount
        for (int i = 0; i < 64; i++) begin
            if (cases[i][143:136] == 8'h02) begin
                probes.push_back(int'(cases[i][135:128]) * REFRESH_CYCLES
                    + int'(cases[i][31:16]) * H_TOTAL + int'(cases[i][15:0]));
            end
        end
        @(negedge px_clk);
        color_on = vga_player_pkg::color_t'($urandom);
        do begin
            color_off = vga_player_pkg::color_t'($urandom);
        end while (color_off == color_on);
        repeat (4) @(negedge px_clk);
        check_sync("sel_n in reset", sel_n, 1);
        check_sync("io_oe in reset", qspi_pins.io_oe, 0);
        check_sync("sound_n in reset", sound_n, 1);
        check_rgb("colour in reset", rgb, expand_color(color_off));
        rst = 1'b0;
        wait (reads_done == N_READS);
        repeat (4) @(negedge px_clk);
        if (probe_ptr != probes.size()) begin
            other_errs++;
            $display("only %0d of %0d probe points were reached", probe_ptr, probes.size());
        end
        if (addr_cnt != N_READS) begin
            other_errs++;
            $display("only %0d of %0d row reads shifted out a full address", addr_cnt,
                     N_READS);
        end
        // pulses must still be arriving at the end of the run
        if (hs_fall < 0 || cyc - 1 - hs_fall >= H_TOTAL) begin
            other_errs++;
            $display("hsync stopped pulsing before the end of the run");
        end
        if (vs_fall < 0 || cyc - 1 - vs_fall >= REFRESH_CYCLES) begin
            other_errs++;
            $display("vsync stopped pulsing before the end of the run");
        end
        print_error_counts();
        if (addr_errs + rgb_errs + sync_errs + pwm_errs + other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/vga_player_cases.txt */
// tag 01: 01_row_data[127:0] (top 48 bits are sound words, low 80 bits pixels)
// tag 02: 02_refresh_0000 x6_vcount_hcount, sorted by time
01_00_8040_20c0_f010_ffff_0000_aaaa_5555_f00f
01_01_ff00_7f80_0102_8001_c003_e007_f00f_ff00
01_02_1234_5678_9abc_0f0f_f0f0_3c3c_c3c3_a5a5
01_3c_00ff_8080_4040_ffff_ffff_0000_0000_1111
01_3d_c000_4000_e000_aaaa_aaaa_5555_5555_0001
01_77_7777_6666_5555_8000_0000_0000_0000_0001
02_00_0000_0000_0000_0000_0000_0000_0002_0005
02_00_0000_0000_0000_0000_0000_0000_0008_0000
02_00_0000_0000_0000_0000_0000_0000_000a_0278
02_00_0000_0000_0000_0000_0000_0000_0010_013f
02_00_0000_0000_0000_0000_0000_0000_01e5_0100
02_01_0000_0000_0000_0000_0000_0000_0003_0007
02_01_0000_0000_0000_0000_0000_0000_000c_0290
02_02_0000_0000_0000_0000_0000_0000_0011_00a0
02_03_0000_0000_0000_0000_0000_0000_0000_0000
02_03_0000_0000_0000_0000_0000_0000_0009_01f8
02_04_0000_0000_0000_0000_0000_0000_01df_027f
02_05_0000_0000_0000_0000_0000_0000_01e2_0010
02_06_0000_0000_0000_0000_0000_0000_0004_0009
02_06_0000_0000_0000_0000_0000_0000_000f_0150

/* vga_player.f */
rtl/vga_player_pkg.sv
rtl/vga_timing.sv
rtl/frame_sequencer.sv
rtl/qspi_row_reader.sv
rtl/row_buffer.sv
rtl/pixel_color.sv
rtl/pwm_audio.sv
rtl/vga_player_top.sv
sim/qspi_flash_model.sv
sim/tb_vga_player.sv
